// File: common/axi_pkg.sv
package axi_pkg;

  localparam int AXI_LEN_WIDTH   = 8;
  localparam int AXI_ID_WIDTH    = 4;
  localparam int BURST_CNT_WIDTH = 16;

  typedef logic [AXI_LEN_WIDTH-1:0]   axi_len_t;
  typedef logic [AXI_ID_WIDTH-1:0]    axi_id_t;
  typedef logic [2:0]                 axi_size_t;
  typedef logic [1:0]                 axi_burst_t;
  typedef logic [1:0]                 axi_resp_t;
  typedef logic [BURST_CNT_WIDTH-1:0] burst_cnt_t;

  localparam axi_burst_t AXI_BURST_INCR = 2'b01;
  localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;

  // Bursts accepted on AW whose data has not yet gone out on W
  localparam int AXI_MAX_AHEAD = 4;

endpackage

// File: common/report_pkg.sv
package report_pkg;

  localparam int STAT_WIDTH = 32;
  localparam int HEX_DIGITS = STAT_WIDTH / 4;

  typedef logic [STAT_WIDTH-1:0] stat_t;
  typedef logic [7:0]            byte_t;
  typedef logic [3:0]            hex_digit_t;

  // ASCII characters used in the report line
  localparam byte_t CHAR_0  = 8'h30;
  localparam byte_t CHAR_A  = 8'h41;
  localparam byte_t CHAR_E  = 8'h45;
  localparam byte_t CHAR_W  = 8'h57;
  localparam byte_t CHAR_EQ = 8'h3d;
  localparam byte_t CHAR_SP = 8'h20;
  localparam byte_t CHAR_CR = 8'h0d;
  localparam byte_t CHAR_LF = 8'h0a;

endpackage

// File: hw/perf_ctrl.sv
`timescale 1ns/1ps

module perf_ctrl #(
  parameter int ADDR_WIDTH = 20
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  logic [ADDR_WIDTH-1:0] cmd_base_addr,
  input  axi_pkg::axi_len_t     cmd_beats,
  input  axi_pkg::burst_cnt_t   cmd_bursts,

  output logic                  run_start,
  output logic [ADDR_WIDTH-1:0] run_base_addr,
  output axi_pkg::axi_len_t     run_len,
  output axi_pkg::burst_cnt_t   run_bursts,
  output logic                  stat_clear,
  input  logic                  run_busy,

  output logic                  report_start,
  input  logic                  report_done
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_WAIT_RUN,
    S_REPORT,
    S_WAIT_REPORT
  } state_t;

  state_t state;
  state_t state_next;

  assign cmd_ready    = (state == S_IDLE);
  assign run_start    = (state == S_START);
  assign stat_clear   = (state == S_START);
  assign report_start = (state == S_REPORT);

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:        if (cmd_valid) state_next = S_START;
      S_START:       state_next = S_WAIT_RUN;
      // Generator raises busy the cycle after run_start
      S_WAIT_RUN:    if (!run_busy) state_next = S_REPORT;
      S_REPORT:      state_next = S_WAIT_REPORT;
      S_WAIT_REPORT: if (report_done) state_next = S_IDLE;
      default:       state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      run_base_addr <= cmd_base_addr;
      run_len       <= cmd_beats;
      run_bursts    <= cmd_bursts;
    end
  end

endmodule

// File: axi_wr/axi_wr_gen.sv
`timescale 1ns/1ps

module axi_wr_gen #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 32
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    run_start,
  input  logic [ADDR_WIDTH-1:0]   run_base_addr,
  input  axi_pkg::axi_len_t       run_len,
  input  axi_pkg::burst_cnt_t     run_bursts,
  output logic                    run_busy,

  output logic                    m_axi_awvalid,
  output logic [ADDR_WIDTH-1:0]   m_axi_awaddr,
  output axi_pkg::axi_id_t        m_axi_awid,
  output axi_pkg::axi_len_t       m_axi_awlen,
  output axi_pkg::axi_size_t      m_axi_awsize,
  output axi_pkg::axi_burst_t     m_axi_awburst,
  input  logic                    m_axi_awready,
  output logic                    m_axi_wvalid,
  output logic [DATA_WIDTH-1:0]   m_axi_wdata,
  output logic [DATA_WIDTH/8-1:0] m_axi_wstrb,
  output logic                    m_axi_wlast,
  input  logic                    m_axi_wready,
  input  logic                    m_axi_bvalid,
  input  axi_pkg::axi_id_t        m_axi_bid,
  input  axi_pkg::axi_resp_t      m_axi_bresp,
  output logic                    m_axi_bready
);

  import axi_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int AXI_SIZE   = $clog2(STRB_WIDTH);

  axi_len_t              len_r;
  logic [ADDR_WIDTH-1:0] aw_addr;
  logic [ADDR_WIDTH-1:0] w_addr;
  logic [ADDR_WIDTH-1:0] burst_stride;

  logic                  awvalid_r;
  logic                  wvalid_r;
  burst_cnt_t            aw_left;
  burst_cnt_t            aw_left_next;
  burst_cnt_t            b_left;
  logic [2:0]            pend;
  logic [2:0]            pend_next;
  axi_len_t              w_beat;

  logic                  aw_hs;
  logic                  w_hs;
  logic                  w_last_hs;
  logic                  b_hs;

  assign m_axi_awvalid = awvalid_r;
  assign m_axi_awaddr  = aw_addr;
  assign m_axi_awid    = '0;
  assign m_axi_awlen   = len_r;
  assign m_axi_awsize  = axi_size_t'(AXI_SIZE);
  assign m_axi_awburst = AXI_BURST_INCR;

  assign m_axi_wvalid  = wvalid_r;
  // Each beat carries its own byte address
  assign m_axi_wdata   = DATA_WIDTH'(w_addr);
  assign m_axi_wstrb   = '1;
  assign m_axi_wlast   = (w_beat == len_r);

  assign m_axi_bready  = (b_left != '0);

  assign aw_hs     = m_axi_awvalid && m_axi_awready;
  assign w_hs      = m_axi_wvalid && m_axi_wready;
  assign w_last_hs = w_hs && m_axi_wlast;
  assign b_hs      = m_axi_bvalid && m_axi_bready && (m_axi_bid == m_axi_awid);

  assign burst_stride = ADDR_WIDTH'({1'b0, len_r} + 9'd1) << AXI_SIZE;

  assign run_busy = (aw_left != '0) || (pend != '0) || (b_left != '0);

  always_comb begin
    aw_left_next = aw_hs ? aw_left - 1'b1 : aw_left;
    pend_next    = pend;
    if (aw_hs && !w_last_hs) begin
      pend_next = pend + 3'd1;
    end else if (!aw_hs && w_last_hs) begin
      pend_next = pend - 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awvalid_r <= 1'b0;
      wvalid_r  <= 1'b0;
      aw_left   <= '0;
      pend      <= '0;
      b_left    <= '0;
      w_beat    <= '0;
    end else if (run_start) begin
      awvalid_r <= (run_bursts != '0);
      wvalid_r  <= 1'b0;
      aw_left   <= run_bursts;
      pend      <= '0;
      b_left    <= run_bursts;
      w_beat    <= '0;
    end else begin
      // AW stalls once it is AXI_MAX_AHEAD bursts in front of W
      awvalid_r <= (aw_left_next != '0) && (pend_next < 3'(AXI_MAX_AHEAD));
      wvalid_r  <= (pend_next != '0);
      aw_left   <= aw_left_next;
      pend      <= pend_next;
      if (b_hs) begin
        b_left <= b_left - 1'b1;
      end
      if (w_hs) begin
        w_beat <= m_axi_wlast ? '0 : w_beat + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run_start) begin
      len_r   <= run_len;
      aw_addr <= run_base_addr;
      w_addr  <= run_base_addr;
    end else begin
      if (aw_hs) begin
        aw_addr <= aw_addr + burst_stride;
      end
      if (w_hs) begin
        w_addr <= w_addr + ADDR_WIDTH'(STRB_WIDTH);
      end
    end
  end

endmodule

// File: axi_wr/axi_wr_stats.sv
`timescale 1ns/1ps

module axi_wr_stats (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stat_clear,

  input  logic               m_axi_awvalid,
  input  logic               m_axi_awready,
  input  logic               m_axi_wvalid,
  input  logic               m_axi_wready,
  input  logic               m_axi_bvalid,
  input  logic               m_axi_bready,
  input  axi_pkg::axi_resp_t m_axi_bresp,

  output report_pkg::stat_t  stat_aw,
  output report_pkg::stat_t  stat_w,
  output report_pkg::stat_t  stat_err
);

  import axi_pkg::*;
  import report_pkg::*;

  // Counters stick at all ones instead of wrapping
  function automatic stat_t sat_inc(stat_t v);
    return (v == '1) ? v : v + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      stat_aw  <= '0;
      stat_w   <= '0;
      stat_err <= '0;
    end else begin
      if (m_axi_awvalid && m_axi_awready) begin
        stat_aw <= sat_inc(stat_aw);
      end
      if (m_axi_wvalid && m_axi_wready) begin
        stat_w <= sat_inc(stat_w);
      end
      if (m_axi_bvalid && m_axi_bready && (m_axi_bresp != AXI_RESP_OKAY)) begin
        stat_err <= sat_inc(stat_err);
      end
    end
  end

endmodule

// File: report/report_fmt.sv
`timescale 1ns/1ps

module report_fmt (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              report_start,

  input  report_pkg::stat_t stat_aw,
  input  report_pkg::stat_t stat_w,
  input  report_pkg::stat_t stat_err,

  output logic              report_done,

  output logic              tx_valid,
  output report_pkg::byte_t tx_data,
  input  logic              tx_ready
);

  import report_pkg::*;

  typedef enum logic [2:0] {
    F_IDLE,
    F_LABEL,
    F_DIGITS,
    F_EOL,
    F_DONE
  } state_t;

  state_t     state;
  logic [1:0] fld;
  logic [2:0] idx;
  stat_t      cur;
  stat_t      snap_w;
  stat_t      snap_err;
  byte_t      label_char;
  logic       tx_hs;
  logic       last_digit;

  function automatic byte_t hex_char(hex_digit_t d);
    if (d < 4'd10) begin
      return CHAR_0 + byte_t'(d);
    end
    return CHAR_A + byte_t'(d - 4'd10);
  endfunction

  assign tx_hs       = tx_valid && tx_ready;
  assign tx_valid    = (state == F_LABEL) || (state == F_DIGITS) || (state == F_EOL);
  assign report_done = (state == F_DONE);
  assign last_digit  = (idx == 3'(HEX_DIGITS - 1));

  // Labels are "AW=", " W=" and " E="
  always_comb begin
    case (idx)
      3'd0:    label_char = (fld == 2'd0) ? CHAR_A : CHAR_SP;
      3'd1:    label_char = (fld == 2'd2) ? CHAR_E : CHAR_W;
      default: label_char = CHAR_EQ;
    endcase
  end

  always_comb begin
    case (state)
      F_LABEL:  tx_data = label_char;
      F_DIGITS: tx_data = hex_char(cur[STAT_WIDTH-1 -: 4]);
      F_EOL:    tx_data = (idx == 3'd0) ? CHAR_CR : CHAR_LF;
      default:  tx_data = CHAR_SP;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= F_IDLE;
      fld   <= '0;
      idx   <= '0;
    end else begin
      case (state)
        F_IDLE: begin
          if (report_start) begin
            state <= F_LABEL;
            fld   <= '0;
            idx   <= '0;
          end
        end
        F_LABEL: begin
          if (tx_hs) begin
            if (idx == 3'd2) begin
              idx   <= '0;
              state <= F_DIGITS;
            end else begin
              idx <= idx + 3'd1;
            end
          end
        end
        F_DIGITS: begin
          if (tx_hs) begin
            if (last_digit) begin
              idx <= '0;
              if (fld == 2'd2) begin
                state <= F_EOL;
              end else begin
                fld   <= fld + 2'd1;
                state <= F_LABEL;
              end
            end else begin
              idx <= idx + 3'd1;
            end
          end
        end
        F_EOL: begin
          if (tx_hs) begin
            if (idx == 3'd1) begin
              state <= F_DONE;
            end else begin
              idx <= idx + 3'd1;
            end
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  // Most significant nibble goes first, so shift left after each digit
  always_ff @(posedge clk) begin
    if ((state == F_IDLE) && report_start) begin
      cur      <= stat_aw;
      snap_w   <= stat_w;
      snap_err <= stat_err;
    end else if ((state == F_DIGITS) && tx_hs) begin
      if (last_digit) begin
        cur <= (fld == 2'd0) ? snap_w : snap_err;
      end else begin
        cur <= cur << 4;
      end
    end
  end

endmodule

// File: report/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              tx_valid,
  input  report_pkg::byte_t tx_data,
  output logic              tx_ready,
  output logic              utx_pin
);

  localparam int CNT_WIDTH = $clog2(CLKS_PER_BIT + 1);

  // Frame is stop, data LSB first, start; shifted out from bit 0
  logic [9:0]           shreg;
  logic [3:0]           bits_left;
  logic [CNT_WIDTH-1:0] bit_cnt;
  logic                 bit_end;

  assign tx_ready = (bits_left == 4'd0);
  assign utx_pin  = shreg[0];
  assign bit_end  = (bit_cnt == CNT_WIDTH'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shreg     <= '1;
      bits_left <= 4'd0;
      bit_cnt   <= '0;
    end else if (tx_valid && tx_ready) begin
      shreg     <= {1'b1, tx_data, 1'b0};
      bits_left <= 4'd10;
      bit_cnt   <= '0;
    end else if (bits_left != 4'd0) begin
      if (bit_end) begin
        bit_cnt   <= '0;
        shreg     <= {1'b1, shreg[9:1]};
        bits_left <= bits_left - 4'd1;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

// File: hw/axi_perf.sv
`timescale 1ns/1ps

module axi_perf #(
  parameter int ADDR_WIDTH   = 20,
  parameter int DATA_WIDTH   = 32,
  parameter int CLKS_PER_BIT = 868
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  logic [ADDR_WIDTH-1:0]   cmd_base_addr,
  input  axi_pkg::axi_len_t       cmd_beats,
  input  axi_pkg::burst_cnt_t     cmd_bursts,

  output logic                    utx_pin,

  output logic                    m_axi_awvalid,
  output logic [ADDR_WIDTH-1:0]   m_axi_awaddr,
  output axi_pkg::axi_id_t        m_axi_awid,
  output axi_pkg::axi_len_t       m_axi_awlen,
  output axi_pkg::axi_size_t      m_axi_awsize,
  output axi_pkg::axi_burst_t     m_axi_awburst,
  input  logic                    m_axi_awready,
  output logic                    m_axi_wvalid,
  output logic [DATA_WIDTH-1:0]   m_axi_wdata,
  output logic [DATA_WIDTH/8-1:0] m_axi_wstrb,
  output logic                    m_axi_wlast,
  input  logic                    m_axi_wready,
  input  logic                    m_axi_bvalid,
  input  axi_pkg::axi_id_t        m_axi_bid,
  input  axi_pkg::axi_resp_t      m_axi_bresp,
  output logic                    m_axi_bready
);

  import axi_pkg::*;
  import report_pkg::*;

  logic                  run_start;
  logic [ADDR_WIDTH-1:0] run_base_addr;
  axi_len_t              run_len;
  burst_cnt_t            run_bursts;
  logic                  run_busy;
  logic                  stat_clear;
  logic                  report_start;
  logic                  report_done;

  stat_t                 stat_aw;
  stat_t                 stat_w;
  stat_t                 stat_err;

  logic                  tx_valid;
  logic                  tx_ready;
  byte_t                 tx_data;

  perf_ctrl #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) perf_ctrl_inst (
    .clk, .rst_n,
    .cmd_valid, .cmd_ready, .cmd_base_addr, .cmd_beats, .cmd_bursts,
    .run_start, .run_base_addr, .run_len, .run_bursts, .stat_clear, .run_busy,
    .report_start, .report_done
  );

  axi_wr_gen #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) axi_wr_gen_inst (
    .clk, .rst_n,
    .run_start, .run_base_addr, .run_len, .run_bursts, .run_busy,
    .m_axi_awvalid, .m_axi_awaddr, .m_axi_awid, .m_axi_awlen,
    .m_axi_awsize, .m_axi_awburst, .m_axi_awready,
    .m_axi_wvalid, .m_axi_wdata, .m_axi_wstrb, .m_axi_wlast, .m_axi_wready,
    .m_axi_bvalid, .m_axi_bid, .m_axi_bresp, .m_axi_bready
  );

  axi_wr_stats axi_wr_stats_inst (
    .clk, .rst_n, .stat_clear,
    .m_axi_awvalid, .m_axi_awready,
    .m_axi_wvalid, .m_axi_wready,
    .m_axi_bvalid, .m_axi_bready, .m_axi_bresp,
    .stat_aw, .stat_w, .stat_err
  );

  report_fmt report_fmt_inst (
    .clk, .rst_n, .report_start,
    .stat_aw, .stat_w, .stat_err,
    .report_done,
    .tx_valid, .tx_data, .tx_ready
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_tx_inst (
    .clk, .rst_n,
    .tx_valid, .tx_data, .tx_ready,
    .utx_pin
  );

endmodule

// File: verif/axi_perf_checker.sv
`timescale 1ns/1ps

module axi_perf_checker #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 32
) (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    m_axi_awvalid,
  input logic                    m_axi_awready,
  input logic [ADDR_WIDTH-1:0]   m_axi_awaddr,
  input axi_pkg::axi_id_t        m_axi_awid,
  input axi_pkg::axi_len_t       m_axi_awlen,
  input axi_pkg::axi_size_t      m_axi_awsize,
  input axi_pkg::axi_burst_t     m_axi_awburst,
  input logic                    m_axi_wvalid,
  input logic                    m_axi_wready,
  input logic [DATA_WIDTH-1:0]   m_axi_wdata,
  input logic [DATA_WIDTH/8-1:0] m_axi_wstrb,
  input logic                    m_axi_wlast,
  input logic                    m_axi_bready,
  input logic                    tx_valid
);

  int fail_count = 0;

  // AW request holds until awready
  assert property (@(posedge clk) disable iff (!rst_n)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid &&
      $stable({m_axi_awaddr, m_axi_awid, m_axi_awlen, m_axi_awsize, m_axi_awburst}))
  else begin
    $error("AW channel changed before awready");
    fail_count++;
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid &&
      $stable({m_axi_wdata, m_axi_wstrb, m_axi_wlast}))
  else begin
    $error("W channel changed before wready");
    fail_count++;
  end

  // Held reset, one edge in
  assert property (@(posedge clk) !rst_n && $past(!rst_n) |->
    !m_axi_awvalid && !m_axi_wvalid && !m_axi_bready && !tx_valid)
  else begin
    $error("Valid or ready output high during reset");
    fail_count++;
  end

endmodule

// File: verif/axi_perf_tb.sv
`timescale 1ns/1ps

module axi_perf_tb;

  import axi_pkg::*;

  localparam int ADDR_WIDTH   = 20;
  localparam int DATA_WIDTH   = 32;
  localparam int CLKS_PER_BIT = 8;
  localparam int TEST_WORDS   = 64;
  localparam int LINE_BYTES   = 35;
  localparam int RUN_LIMIT    = 200000;
  localparam logic [31:0] LFSR_SEED = 32'h9f6029f4;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    cmd_valid;
  logic                    cmd_ready;
  logic [ADDR_WIDTH-1:0]   cmd_base_addr;
  axi_len_t                cmd_beats;
  burst_cnt_t              cmd_bursts;
  logic                    utx_pin;
  logic                    m_axi_awvalid;
  logic [ADDR_WIDTH-1:0]   m_axi_awaddr;
  axi_id_t                 m_axi_awid;
  axi_len_t                m_axi_awlen;
  axi_size_t               m_axi_awsize;
  axi_burst_t              m_axi_awburst;
  logic                    m_axi_awready;
  logic                    m_axi_wvalid;
  logic [DATA_WIDTH-1:0]   m_axi_wdata;
  logic [DATA_WIDTH/8-1:0] m_axi_wstrb;
  logic                    m_axi_wlast;
  logic                    m_axi_wready;
  logic                    m_axi_bvalid;
  axi_id_t                 m_axi_bid;
  axi_resp_t               m_axi_bresp;
  logic                    m_axi_bready;

  // Four words per test for base, beats, bursts and error burst index
  logic [31:0] tests [0:TEST_WORDS-1];
  logic [31:0] cur_base;
  logic [31:0] cur_beats;
  logic [31:0] cur_bursts;
  logic [31:0] cur_err;
  logic        stall_mode;
  logic        run_active;
  logic [31:0] lfsr;
  int          aw_cnt;
  int          w_cnt;
  int          wlast_cnt;
  int          b_cnt;
  int          b_issued;

  always #10 clk = ~clk;

  axi_perf #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) axi_perf_inst (.*);

  bind axi_perf axi_perf_checker #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) axi_perf_checker_inst (.*);

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp)
    else report_failure($sformatf("Fail %s: expected %h, got %h", name, exp, got));
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // Heavy stalls leave ready high on about a quarter of the cycles
  task automatic gate_ready(output logic r);
    logic first;
    if (!stall_mode) begin
      r = 1'b1;
    end else begin
      lfsr  = lfsr_next(lfsr);
      first = lfsr[0];
      lfsr  = lfsr_next(lfsr);
      r     = first & lfsr[0];
    end
  endtask

  function automatic string hex8(input logic [31:0] v);
    string digits = "0123456789ABCDEF";
    string s = "";
    for (int i = 7; i >= 0; i--) begin
      s = {s, digits.substr(int'(v[i*4 +: 4]), int'(v[i*4 +: 4]))};
    end
    return s;
  endfunction

  // Start bit is seen half a clock late, so four more clocks reach mid-bit
  task automatic receive_byte(input int limit, output logic [7:0] b);
    int waited;
    waited = 0;
    @(negedge clk);
    while (utx_pin !== 1'b0) begin
      assert (waited < limit) else report_failure("Timed out waiting for a UART start bit");
      waited++;
      @(negedge clk);
    end
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    assert (utx_pin === 1'b0) else report_failure("UART start bit too short");
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b[i] = utx_pin;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    assert (utx_pin === 1'b1) else report_failure("UART stop bit missing");
  endtask

  // Slave model samples handshakes at the falling edge and drives after the rising edge
  initial begin : slave_model
    logic b_fire;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    m_axi_bid     = '0;
    m_axi_bresp   = '0;
    lfsr          = LFSR_SEED;
    forever begin
      @(negedge clk);
      b_fire = 1'b0;
      assert (axi_perf_inst.axi_perf_checker_inst.fail_count == 0)
      else report_failure("Protocol checker flagged an error");
      if (rst_n) begin
        if (run_active) begin
          assert (!cmd_ready) else report_failure("cmd_ready rose before the report ended");
        end
        if (cmd_valid && cmd_ready) begin
          aw_cnt    = 0;
          w_cnt     = 0;
          wlast_cnt = 0;
          b_cnt     = 0;
          b_issued  = 0;
        end
        if (m_axi_awvalid && m_axi_awready) begin
          assert (aw_cnt < cur_bursts) else report_failure("More AW bursts than commanded");
          expect_equal("m_axi_awaddr", m_axi_awaddr, cur_base + aw_cnt * cur_beats * 4);
          expect_equal("m_axi_awlen", m_axi_awlen, cur_beats - 1);
          expect_equal("m_axi_awsize", m_axi_awsize, 2);
          expect_equal("m_axi_awburst", m_axi_awburst, 1);
          expect_equal("m_axi_awid", m_axi_awid, 0);
          aw_cnt++;
        end
        if (m_axi_wvalid && m_axi_wready) begin
          assert (w_cnt < cur_bursts * cur_beats)
          else report_failure("More W beats than commanded");
          expect_equal("m_axi_wdata", m_axi_wdata, cur_base + w_cnt * 4);
          expect_equal("m_axi_wstrb", m_axi_wstrb, 4'hf);
          expect_equal("m_axi_wlast", m_axi_wlast, (w_cnt % cur_beats) == cur_beats - 1);
          if (m_axi_wlast) wlast_cnt++;
          w_cnt++;
        end
        if (m_axi_bvalid && m_axi_bready) begin
          b_cnt++;
          b_fire = 1'b1;
        end
      end
      @(posedge clk);
      #1;
      if (b_fire) m_axi_bvalid = 1'b0;
      if (!m_axi_bvalid && b_issued < wlast_cnt) begin
        gate_ready(m_axi_bvalid);
        if (m_axi_bvalid) begin
          m_axi_bresp = (b_issued == cur_err) ? 2'b10 : 2'b00;
          b_issued++;
        end
      end
      gate_ready(m_axi_awready);
      gate_ready(m_axi_wready);
    end
  end

  initial begin : main_flow
    int          t;
    int          waited;
    logic [7:0]  rx;
    logic [7:0]  exp;
    logic [31:0] errs;
    string       line;
    rst_n         = 1'b0;
    cmd_valid     = 1'b0;
    cmd_base_addr = '0;
    cmd_beats     = '0;
    cmd_bursts    = '0;
    run_active    = 1'b0;
    stall_mode    = 1'b0;
    cur_err       = '1;
    for (int i = 0; i < TEST_WORDS; i++) tests[i] = '0;
    $readmemh("verif/axi_perf_tests.txt", tests);
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    expect_equal("cmd_ready", cmd_ready, 1);
    t = 0;
    while (t < TEST_WORDS / 4 && tests[4*t+1] != 0) begin
      cur_base   = tests[4*t];
      cur_beats  = tests[4*t+1];
      cur_bursts = tests[4*t+2];
      cur_err    = tests[4*t+3];
      stall_mode = t[0];
      errs = (cur_err < cur_bursts) ? 32'd1 : 32'd0;
      line = {"AW=", hex8(cur_bursts), " W=", hex8(cur_bursts * cur_beats), " E=", hex8(errs)};
      @(posedge clk);
      #1;
      cmd_valid     = 1'b1;
      cmd_base_addr = cur_base[ADDR_WIDTH-1:0];
      cmd_beats     = axi_len_t'(cur_beats - 1);
      cmd_bursts    = burst_cnt_t'(cur_bursts);
      waited = 0;
      @(negedge clk);
      while (!cmd_ready) begin
        assert (waited < 20) else report_failure("Command was not accepted");
        waited++;
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      cmd_valid  = 1'b0;
      run_active = 1'b1;
      for (int k = 0; k < LINE_BYTES; k++) begin
        receive_byte((k == 0) ? RUN_LIMIT : 4 * CLKS_PER_BIT, rx);
        exp = (k < LINE_BYTES - 2) ? line.getc(k) : (k == LINE_BYTES - 2) ? 8'h0d : 8'h0a;
        expect_equal($sformatf("utx_pin byte %0d", k), rx, exp);
        // Ready may rise while the line feed is still on the wire
        if (k == LINE_BYTES - 2) run_active = 1'b0;
      end
      expect_equal("m_axi_awvalid handshakes", aw_cnt, cur_bursts);
      expect_equal("m_axi_wvalid handshakes", w_cnt, cur_bursts * cur_beats);
      expect_equal("m_axi_bvalid handshakes", b_cnt, cur_bursts);
      waited = 0;
      @(negedge clk);
      while (!cmd_ready) begin
        assert (waited < 20) else report_failure("cmd_ready did not return after the report");
        waited++;
        @(negedge clk);
      end
      t++;
    end
    if (t == 0 || axi_perf_inst.axi_perf_checker_inst.fail_count != 0) begin
      report_failure((t == 0) ? "No test lines were read" : "Protocol checker flagged errors");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: verif/axi_perf_tests.txt
// base     beats    bursts   error burst index (ffffffff for none)
// every second line runs with heavy slave stalls
00000100 00000004 00000003 ffffffff
00000100 00000004 00000003 ffffffff
00002000 00000010 00000005 00000002
00002000 00000010 00000005 00000002
00080000 00000100 00000002 00000001
0000fff0 00000001 00000004 00000000
00000000 00000002 00000001 ffffffff
00040000 00000008 00000006 00000005

// File: sources.f
common/axi_pkg.sv
common/report_pkg.sv
hw/perf_ctrl.sv
axi_wr/axi_wr_gen.sv
axi_wr/axi_wr_stats.sv
report/report_fmt.sv
report/uart_tx.sv
hw/axi_perf.sv
verif/axi_perf_checker.sv
verif/axi_perf_tb.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := axi_perf_tb
FILE_LIST := sources.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+100
LOG       := sim.log
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
